// File: include/osc_defs.svh
// oscilloscope data path constants
`ifndef OSC_DEFS_SVH
`define OSC_DEFS_SVH

// ======================================================================
// widths and record size
// ======================================================================
`define OSC_SAMPLE_W    8     // one adc sample
`define OSC_ADDR_W      6     // record address
`define OSC_DEPTH       64    // samples per record
`define OSC_TB_W        6     // time base, period minus one
`define OSC_REF_W       8     // trigger reference level
`define OSC_REF_INIT    128   // mid scale after reset

// ======================================================================
// trigger dac link
// ======================================================================
`define OSC_DAC_W       16    // spi frame bits
`define OSC_DAC_CMD_CH1 4'd1  // dac channel a
`define OSC_DAC_CMD_CH2 4'd2  // dac channel b
`define OSC_SCLK_HALF   4     // clk_50 cycles per sclk phase

// reset pulse lengths in clk_50 cycles
`define OSC_COLD_EXT    6
`define OSC_WARM_EXT    2
`define OSC_DEBUG_EXT   32

`endif

// File: src/osc_pkg.sv
// oscilloscope shared types
`default_nettype none

`include "osc_defs.svh"

package osc_pkg;

  typedef logic [`OSC_SAMPLE_W-1:0] sample_t;     // raw adc code
  typedef logic [`OSC_ADDR_W-1:0]   addr_t;       // record address
  typedef logic [`OSC_TB_W-1:0]     time_base_t;  // sample period minus one
  typedef logic [`OSC_REF_W-1:0]    ref_level_t;  // trigger level
  typedef logic [`OSC_DAC_W-1:0]    dac_word_t;   // one spi frame

  // capture fsm states, as seen in the status word
  typedef enum logic [1:0] {
    CAP_ARMED     = 2'b00,  // waiting for trigger edge
    CAP_CAPTURING = 2'b01,  // filling the record
    CAP_DONE      = 2'b10   // record full, waits for arm
  } cap_state_t;

  // status word read by the processor side, msb first
  typedef struct packed {
    logic [5:0] reserved;     // reads zero
    cap_state_t cap_state_2;  // bits 25..24
    cap_state_t cap_state_1;  // bits 23..22
    time_base_t time_base;    // bits 21..16
    ref_level_t ref_level_2;  // bits 15..8
    ref_level_t ref_level_1;  // bits 7..0
  } status_t;

endpackage

`default_nettype wire

// File: src/sample_clock_gen.sv
// adc time base
`timescale 1ns/1ps
`default_nettype none

module sample_clock_gen (
  input  wire                     clk_50,
  input  wire                     arst_n,
  input  wire osc_pkg::time_base_t time_base,   // period minus one
  output logic                    adc_clk_en,  // one-cycle sample strobe
  output logic                    adc_clk      // clock to both adcs
);

  osc_pkg::time_base_t cnt;      // position in the sample period
  osc_pkg::time_base_t cnt_nxt;

  // >= so a smaller time base written mid-period reloads at once
  assign adc_clk_en = (cnt >= time_base);
  assign cnt_nxt    = adc_clk_en ? '0 : cnt + 1'b1;

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= '0;
      adc_clk <= 1'b0;
    end else begin
      cnt     <= cnt_nxt;
      adc_clk <= (cnt_nxt <= (time_base >> 1));  // high in lower half, glitch free
    end
  end

  // strobe is a single cycle unless the period is one cycle
  a_strobe_single : assert property (
    @(posedge clk_50) disable iff (!arst_n)
    adc_clk_en |=> (!adc_clk_en || time_base == '0)
  ) else $error("adc_clk_en held high with nonzero time base");

endmodule

`default_nettype wire

// File: src/capture_channel.sv
// triggered record capture
`timescale 1ns/1ps
`default_nettype none

`include "osc_defs.svh"

module capture_channel (
  input  wire                   clk_50,
  input  wire                   arst_n,
  input  wire                   adc_clk_en,   // sample strobe
  input  wire osc_pkg::sample_t adc_samples,
  input  wire                   trigger,
  input  wire                   arm,          // re-arm after done
  output logic                  mem_write,
  output osc_pkg::addr_t        mem_addr,
  output osc_pkg::sample_t      mem_data,
  output osc_pkg::cap_state_t   state
);

  localparam osc_pkg::addr_t LAST_ADDR = osc_pkg::addr_t'(`OSC_DEPTH - 1);

  logic           trig_q;     // trigger at previous strobe
  logic           trig_rise;
  osc_pkg::addr_t wr_addr;    // next record address
  logic           cap_end;    // last sample issued, go done
  logic           start;
  logic           take;       // store this strobe's sample

  // ======================================================================
  // strobe qualified trigger edge
  // ======================================================================
  assign trig_rise = trigger & ~trig_q;
  assign start     = (state == osc_pkg::CAP_ARMED) & adc_clk_en & trig_rise;
  assign take      = start |
                     ((state == osc_pkg::CAP_CAPTURING) & ~cap_end & adc_clk_en);

  // ======================================================================
  // capture fsm and address counter
  // ======================================================================
  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      state     <= osc_pkg::CAP_ARMED;
      trig_q    <= 1'b0;
      wr_addr   <= '0;
      cap_end   <= 1'b0;
      mem_write <= 1'b0;
    end else begin
      mem_write <= take;                  // one cycle after the strobe
      if (adc_clk_en)
        trig_q <= trigger;                // edge seen strobe to strobe
      if (take) begin
        wr_addr <= wr_addr + 1'b1;        // wraps to 0 after the last one
        if (wr_addr == LAST_ADDR)
          cap_end <= 1'b1;
      end
      case (state)
        osc_pkg::CAP_ARMED: begin
          if (start)
            state <= osc_pkg::CAP_CAPTURING;
        end
        osc_pkg::CAP_CAPTURING: begin
          if (cap_end) begin              // last write is on the port now
            state   <= osc_pkg::CAP_DONE;
            cap_end <= 1'b0;
          end
        end
        osc_pkg::CAP_DONE: begin
          if (arm)
            state <= osc_pkg::CAP_ARMED;  // trigger ignored until here
        end
        default: state <= osc_pkg::CAP_ARMED;
      endcase
    end
  end

  // write port payload, qualified by mem_write
  always_ff @(posedge clk_50) begin
    if (take) begin
      mem_addr <= wr_addr;
      mem_data <= adc_samples;
    end
  end

  a_no_write_done : assert property (
    @(posedge clk_50) disable iff (!arst_n)
    (state == osc_pkg::CAP_DONE) |-> !mem_write
  ) else $error("record write while channel done");

endmodule

`default_nettype wire

// File: src/quad_encoder_level.sv
// rotary encoder level control
`timescale 1ns/1ps
`default_nettype none

`include "osc_defs.svh"

module quad_encoder_level (
  input  wire                 clk_50,
  input  wire                 arst_n,
  input  wire                 re_a,           // encoder phase a, async
  input  wire                 re_b,           // encoder phase b, async
  output osc_pkg::ref_level_t ref_level,
  output logic                level_changed   // one pulse per real step
);

  logic [1:0] a_sync;   // two-flop synchronizer
  logic [1:0] b_sync;
  logic       a_q;      // for the edge detect
  logic       a_rise;
  logic       step_up;
  logic       step_dn;

  assign a_rise = a_sync[1] & ~a_q;

  // b decides direction, limits block the step
  assign step_up = a_rise & ~b_sync[1] & (ref_level != '1);
  assign step_dn = a_rise &  b_sync[1] & (ref_level != '0);

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      a_sync        <= '0;
      b_sync        <= '0;
      a_q           <= 1'b0;
      ref_level     <= osc_pkg::ref_level_t'(`OSC_REF_INIT);
      level_changed <= 1'b0;
    end else begin
      a_sync        <= {a_sync[0], re_a};
      b_sync        <= {b_sync[0], re_b};
      a_q           <= a_sync[1];
      level_changed <= step_up | step_dn;   // aligned with the new level
      if (step_up)
        ref_level <= ref_level + 1'b1;
      else if (step_dn)
        ref_level <= ref_level - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/dac_spi_writer.sv
// trigger dac spi writer
`timescale 1ns/1ps
`default_nettype none

`include "osc_defs.svh"

module dac_spi_writer (
  input  wire                      clk_50,
  input  wire                      arst_n,
  input  wire osc_pkg::ref_level_t ref_level_1,
  input  wire osc_pkg::ref_level_t ref_level_2,
  input  wire                      changed_1,   // level step, channel 1
  input  wire                      changed_2,
  output logic                     sclk,
  output logic                     sdata,
  output logic                     cs_n
);

  localparam int DIV_W = $clog2(`OSC_SCLK_HALF + 1);
  localparam int BIT_W = $clog2(`OSC_DAC_W);

  logic               pend_1;     // frame owed to channel 1
  logic               pend_2;
  logic [DIV_W-1:0]   div_cnt;    // cycles within an sclk phase
  logic [BIT_W-1:0]   bit_cnt;    // bits sent in this frame
  osc_pkg::dac_word_t shreg;      // msb goes out first
  osc_pkg::dac_word_t frame;
  logic               start;
  logic               phase_end;
  logic               frame_end;

  // ======================================================================
  // frame select, channel 1 wins
  // ======================================================================
  assign start = cs_n & (pend_1 | pend_2);   // cs_n high = idle
  assign frame = pend_1 ? {`OSC_DAC_CMD_CH1, ref_level_1, 4'b0000}
                        : {`OSC_DAC_CMD_CH2, ref_level_2, 4'b0000};

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      pend_1 <= 1'b0;
      pend_2 <= 1'b0;
    end else begin
      // steps during a frame fold into one pending write
      pend_1 <= changed_1 | (pend_1 & ~start);
      pend_2 <= changed_2 | (pend_2 & ~(start & ~pend_1));
    end
  end

  // ======================================================================
  // serializer
  // ======================================================================
  assign phase_end = ~cs_n & (div_cnt == DIV_W'(`OSC_SCLK_HALF - 1));
  assign frame_end = phase_end & sclk & (bit_cnt == BIT_W'(`OSC_DAC_W - 1));
  assign sdata     = shreg[`OSC_DAC_W-1];

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      cs_n    <= 1'b1;
      sclk    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '0;
    end else if (start) begin
      cs_n    <= 1'b0;          // level latched here
      sclk    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= frame;
    end else if (!cs_n) begin
      if (phase_end) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (sclk) begin         // falling sclk, next bit
          shreg   <= {shreg[`OSC_DAC_W-2:0], 1'b0};
          bit_cnt <= bit_cnt + 1'b1;
          if (frame_end)
            cs_n <= 1'b1;       // idle at least one cycle before next frame
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  a_sclk_idle : assert property (
    @(posedge clk_50) disable iff (!arst_n)
    cs_n |-> !sclk
  ) else $error("sclk active with cs_n high");

endmodule

`default_nettype wire

// File: src/reset_pulse_stretch.sv
// reset request pulse stretcher
`timescale 1ns/1ps
`default_nettype none

module reset_pulse_stretch #(
  parameter int pulse_len = 4   // output pulse in clk_50 cycles
) (
  input  wire  clk_50,
  input  wire  arst_n,
  input  wire  req,     // request level, rising edge counts
  output logic pulse
);

  localparam int CNT_W = $clog2(pulse_len + 1);

  logic             req_q;
  logic             req_rise;
  logic [CNT_W-1:0] cnt;      // cycles of pulse left

  assign req_rise = req & ~req_q;
  assign pulse    = (cnt != '0);

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      req_q <= 1'b0;
      cnt   <= '0;
    end else begin
      req_q <= req;
      if (cnt != '0)
        cnt <= cnt - 1'b1;            // running, new edges dropped
      else if (req_rise)
        cnt <= CNT_W'(pulse_len);     // pulse starts next cycle
    end
  end

endmodule

`default_nettype wire

// File: src/osc_top.sv
// oscilloscope data path top
`timescale 1ns/1ps
`default_nettype none

`include "osc_defs.svh"

module osc_top (
  input  wire                      clk_50,
  input  wire                      arst_n,
  input  wire osc_pkg::time_base_t time_base,
  input  wire osc_pkg::sample_t    adc_samples_1,
  input  wire osc_pkg::sample_t    adc_samples_2,
  input  wire                      trigger_1,
  input  wire                      trigger_2,
  input  wire                      arm_1,
  input  wire                      arm_2,
  input  wire                      re_a1,
  input  wire                      re_b1,
  input  wire                      re_a2,
  input  wire                      re_b2,
  input  wire [2:0]                reset_req,     // cold, warm, debug
  output logic                     adc_clk,
  output logic                     adc_clk_en,
  output logic                     mem_write_1,
  output osc_pkg::addr_t           mem_addr_1,
  output osc_pkg::sample_t         mem_data_1,
  output logic                     mem_write_2,
  output osc_pkg::addr_t           mem_addr_2,
  output osc_pkg::sample_t         mem_data_2,
  output logic                     sclk,
  output logic                     sdata,
  output logic                     cs_n,
  output logic                     cold_reset,
  output logic                     warm_reset,
  output logic                     debug_reset,
  output osc_pkg::status_t         oscope_status
);

  osc_pkg::cap_state_t cap_state_1;
  osc_pkg::cap_state_t cap_state_2;
  osc_pkg::ref_level_t ref_level_1;
  osc_pkg::ref_level_t ref_level_2;
  logic                changed_1;
  logic                changed_2;

  // ======================================================================
  // acquisition, one time base for both channels
  // ======================================================================
  sample_clock_gen u_time_base (
    .clk_50, .arst_n, .time_base, .adc_clk_en, .adc_clk
  );

  capture_channel u_chan_1 (
    .clk_50, .arst_n, .adc_clk_en,
    .adc_samples (adc_samples_1), .trigger (trigger_1), .arm (arm_1),
    .mem_write (mem_write_1), .mem_addr (mem_addr_1),
    .mem_data (mem_data_1), .state (cap_state_1)
  );

  capture_channel u_chan_2 (
    .clk_50, .arst_n, .adc_clk_en,
    .adc_samples (adc_samples_2), .trigger (trigger_2), .arm (arm_2),
    .mem_write (mem_write_2), .mem_addr (mem_addr_2),
    .mem_data (mem_data_2), .state (cap_state_2)
  );

  // ======================================================================
  // trigger levels and threshold dac
  // ======================================================================
  quad_encoder_level u_enc_1 (
    .clk_50, .arst_n, .re_a (re_a1), .re_b (re_b1),
    .ref_level (ref_level_1), .level_changed (changed_1)
  );

  quad_encoder_level u_enc_2 (
    .clk_50, .arst_n, .re_a (re_a2), .re_b (re_b2),
    .ref_level (ref_level_2), .level_changed (changed_2)
  );

  dac_spi_writer u_dac (
    .clk_50, .arst_n, .ref_level_1, .ref_level_2,
    .changed_1, .changed_2, .sclk, .sdata, .cs_n
  );

  // reset request stretchers
  reset_pulse_stretch #(.pulse_len(`OSC_COLD_EXT)) u_cold_rst (
    .clk_50, .arst_n, .req (reset_req[0]), .pulse (cold_reset)
  );
  reset_pulse_stretch #(.pulse_len(`OSC_WARM_EXT)) u_warm_rst (
    .clk_50, .arst_n, .req (reset_req[1]), .pulse (warm_reset)
  );
  reset_pulse_stretch #(.pulse_len(`OSC_DEBUG_EXT)) u_debug_rst (
    .clk_50, .arst_n, .req (reset_req[2]), .pulse (debug_reset)
  );

  // status word for the processor side
  assign oscope_status = '{
    reserved:    '0,
    cap_state_2: cap_state_2,
    cap_state_1: cap_state_1,
    time_base:   time_base,
    ref_level_2: ref_level_2,
    ref_level_1: ref_level_1
  };

endmodule

`default_nettype wire

// File: verif/osc_checker.sv
// oscilloscope response checker
`timescale 1ns/1ps
`default_nettype none

`include "osc_defs.svh"

module osc_checker (
  input  wire                      clk_50,
  input  wire                      arst_n,
  input  wire osc_pkg::time_base_t time_base,
  input  wire osc_pkg::sample_t    adc_samples_1,
  input  wire osc_pkg::sample_t    adc_samples_2,
  input  wire                      trigger_1,
  input  wire                      trigger_2,
  input  wire                      arm_1,
  input  wire                      arm_2,
  input  wire                      re_a1,
  input  wire                      re_b1,
  input  wire                      re_a2,
  input  wire                      re_b2,
  input  wire [2:0]                reset_req,
  input  wire                      adc_clk,
  input  wire                      adc_clk_en,
  input  wire                      mem_write_1,
  input  wire osc_pkg::addr_t      mem_addr_1,
  input  wire osc_pkg::sample_t    mem_data_1,
  input  wire                      mem_write_2,
  input  wire osc_pkg::addr_t      mem_addr_2,
  input  wire osc_pkg::sample_t    mem_data_2,
  input  wire                      sclk,
  input  wire                      sdata,
  input  wire                      cs_n,
  input  wire                      cold_reset,
  input  wire                      warm_reset,
  input  wire                      debug_reset,
  input  wire osc_pkg::status_t    oscope_status,
  input  wire                      finish_chk,   // run final checks
  output int                       err_cnt
);

  int                  chk_cnt;
  // capture model per channel
  osc_pkg::cap_state_t m_state [2];
  logic                m_trig_q [2];
  int                  m_cnt [2];        // samples issued
  logic                m_to_done [2];
  logic                exp_wr [2];
  int                  exp_addr [2];
  int                  exp_data [2];
  // sample period
  int                  gap;
  logic                tb_stable;
  logic                seen_strobe;
  int                  tb_last;
  // encoder levels
  int                  m_lvl [2];
  int                  lvl_prev [2];     // level compared one cycle back
  logic                a_prev [2];
  logic [1:0]          pipe_v [2];       // rise seen, waiting to land
  logic [1:0]          pipe_dn [2];
  // dac frames
  logic                cs_q;
  logic                sclk_q;
  logic [15:0]         shw;
  int                  nbits;
  int                  snap [2];
  int                  last_frame [2];
  int                  frames [2];
  // reset stretchers
  int                  rst_cnt [3];
  logic [2:0]          req_q;
  logic                post_rst_done;
  logic                final_done;

  task automatic compare(input string name, input int got, input int exp);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic fail_text(input string what);
    err_cnt++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  // ======================================================================
  // capture model, one call per channel per cycle
  // ======================================================================
  task automatic capture_cycle(input int c, input logic trig, input logic armp,
                               input int smp, input logic wr, input int a, input int d,
                               input int st);
    osc_pkg::cap_state_t old;
    compare($sformatf("mem_write_%0d", c + 1), wr, exp_wr[c]);
    if (exp_wr[c] && wr) begin
      compare($sformatf("mem_addr_%0d", c + 1), a, exp_addr[c]);
      compare($sformatf("mem_data_%0d", c + 1), d, exp_data[c]);
    end
    compare($sformatf("cap_state_%0d", c + 1), st, int'(m_state[c]));
    old = m_state[c];
    exp_wr[c] = 1'b0;
    if (old == osc_pkg::CAP_ARMED && adc_clk_en && trig && !m_trig_q[c]) begin
      exp_wr[c]   = 1'b1;                // record starts at address 0
      exp_addr[c] = 0;
      exp_data[c] = smp;
      m_cnt[c]    = 1;
      m_state[c]  = osc_pkg::CAP_CAPTURING;
    end else if (old == osc_pkg::CAP_CAPTURING && m_to_done[c]) begin
      m_state[c]   = osc_pkg::CAP_DONE;
      m_to_done[c] = 1'b0;
    end else if (old == osc_pkg::CAP_CAPTURING && adc_clk_en && m_cnt[c] < `OSC_DEPTH) begin
      exp_wr[c]   = 1'b1;
      exp_addr[c] = m_cnt[c];
      exp_data[c] = smp;
      m_cnt[c]++;
      if (m_cnt[c] == `OSC_DEPTH)
        m_to_done[c] = 1'b1;
    end else if (old == osc_pkg::CAP_DONE && armp) begin
      m_state[c] = osc_pkg::CAP_ARMED;
    end
    if (adc_clk_en)
      m_trig_q[c] = trig;
  endtask

  // encoder rise lands on the level three cycles later
  task automatic encoder_cycle(input int c, input logic ra, input logic rb);
    if (pipe_v[c][1]) begin
      if (pipe_dn[c][1] && m_lvl[c] > 0)
        m_lvl[c]--;
      else if (!pipe_dn[c][1] && m_lvl[c] < 255)
        m_lvl[c]++;
    end
    pipe_v[c]  = {pipe_v[c][0], ra & ~a_prev[c]};
    pipe_dn[c] = {pipe_dn[c][0], rb};
    a_prev[c]  = ra;
  endtask

  task automatic reset_cycle(input int i, input logic req, input logic pulse, input int len);
    compare($sformatf("reset pulse %0d", i), pulse, rst_cnt[i] != 0);
    if (rst_cnt[i] != 0)
      rst_cnt[i]--;                      // running pulse ignores requests
    else if (req && !req_q[i])
      rst_cnt[i] = len;
    req_q[i] = req;
  endtask

  always @(posedge clk_50) begin
    if (!arst_n) begin
      for (int c = 0; c < 2; c++) begin
        m_state[c] = osc_pkg::CAP_ARMED;
        m_trig_q[c] = 1'b0;
        m_cnt[c] = 0;
        m_to_done[c] = 1'b0;
        exp_wr[c] = 1'b0;
        m_lvl[c] = `OSC_REF_INIT;
        lvl_prev[c] = `OSC_REF_INIT;
        a_prev[c] = 1'b0;
        pipe_v[c] = '0;
        pipe_dn[c] = '0;
        frames[c] = 0;
      end
      for (int i = 0; i < 3; i++)
        rst_cnt[i] = 0;
      req_q = '0;
      gap = 0;
      seen_strobe = 1'b0;
      tb_stable = 1'b0;
      tb_last = time_base;
      cs_q = 1'b1;
      sclk_q = 1'b0;
      nbits = 0;
      post_rst_done = 1'b0;
    end else begin
      if (!post_rst_done) begin
        compare("cs_n", cs_n, 1);
        compare("sclk", sclk, 0);
        post_rst_done = 1'b1;
      end
      // strobe period
      gap++;
      if (time_base != tb_last)
        tb_stable = 1'b0;
      tb_last = time_base;
      // adc clock high for the first half of the period
      if (seen_strobe && tb_stable)
        compare("adc_clk", adc_clk, 2 * (gap - 1) < int'(time_base) + 1);
      if (adc_clk_en) begin
        if (seen_strobe && tb_stable)
          compare("adc_clk_en period", gap, int'(time_base) + 1);
        gap = 0;
        seen_strobe = 1'b1;
        tb_stable = 1'b1;
      end
      compare("status time_base", oscope_status.time_base, time_base);
      compare("status reserved", oscope_status.reserved, 0);
      capture_cycle(0, trigger_1, arm_1, adc_samples_1, mem_write_1, mem_addr_1,
                    mem_data_1, oscope_status.cap_state_1);
      capture_cycle(1, trigger_2, arm_2, adc_samples_2, mem_write_2, mem_addr_2,
                    mem_data_2, oscope_status.cap_state_2);
      compare("ref_level_1", oscope_status.ref_level_1, m_lvl[0]);
      compare("ref_level_2", oscope_status.ref_level_2, m_lvl[1]);
      // dac frame decode
      if (cs_q && !cs_n) begin
        nbits = 0;
        snap[0] = lvl_prev[0];           // level latched at the start edge
        snap[1] = lvl_prev[1];
      end
      if (!cs_n && !sclk_q && sclk) begin
        shw = {shw[14:0], sdata};
        nbits++;
      end
      if (!cs_q && cs_n) begin
        compare("dac frame bits", nbits, `OSC_DAC_W);
        compare("dac frame low nibble", shw[3:0], 0);
        if (shw[15:12] == `OSC_DAC_CMD_CH1 || shw[15:12] == `OSC_DAC_CMD_CH2) begin
          int c;
          c = (shw[15:12] == `OSC_DAC_CMD_CH1) ? 0 : 1;
          compare($sformatf("dac level ch%0d", c + 1), shw[11:4], snap[c]);
          last_frame[c] = shw[11:4];
          frames[c]++;
        end else begin
          fail_text($sformatf("dac frame has unknown command code %0h", shw[15:12]));
        end
      end
      cs_q = cs_n;
      sclk_q = sclk;
      lvl_prev[0] = m_lvl[0];
      lvl_prev[1] = m_lvl[1];
      encoder_cycle(0, re_a1, re_b1);
      encoder_cycle(1, re_a2, re_b2);
      reset_cycle(0, reset_req[0], cold_reset, `OSC_COLD_EXT);
      reset_cycle(1, reset_req[1], warm_reset, `OSC_WARM_EXT);
      reset_cycle(2, reset_req[2], debug_reset, `OSC_DEBUG_EXT);
    end
  end

  // ======================================================================
  // end of run
  // ======================================================================
  initial begin
    err_cnt = 0;
    chk_cnt = 0;
    final_done = 1'b0;
  end

  always @(posedge clk_50) begin
    if (finish_chk && !final_done) begin
      final_done = 1'b1;
      for (int c = 0; c < 2; c++) begin
        if (frames[c] == 0)
          fail_text($sformatf("no dac frame seen for channel %0d", c + 1));
        else
          compare($sformatf("last dac level ch%0d", c + 1), last_frame[c], m_lvl[c]);
      end
      $display("checker: %0d checks, %0d errors", chk_cnt, err_cnt);
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_osc_top.sv
// oscilloscope testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_osc_top;

  // step operations
  localparam int OP_TB      = 0;  // set time base
  localparam int OP_TRIG_UP = 1;
  localparam int OP_TRIG_DN = 2;
  localparam int OP_ARM     = 3;
  localparam int OP_ENC_UP  = 4;  // arg = number of steps
  localparam int OP_ENC_DN  = 5;
  localparam int OP_RST     = 6;  // channel = request bit
  localparam int OP_IDLE    = 7;  // arg = cycles
  localparam int N_STEPS    = 30;

  logic                clk_50;
  logic                arst_n;
  osc_pkg::time_base_t time_base;
  osc_pkg::sample_t    adc_samples_1;
  osc_pkg::sample_t    adc_samples_2;
  logic                trigger_1;
  logic                trigger_2;
  logic                arm_1;
  logic                arm_2;
  logic                re_a1;
  logic                re_b1;
  logic                re_a2;
  logic                re_b2;
  logic [2:0]          reset_req;
  wire                 adc_clk;
  wire                 adc_clk_en;
  wire                 mem_write_1;
  osc_pkg::addr_t      mem_addr_1;
  osc_pkg::sample_t    mem_data_1;
  wire                 mem_write_2;
  osc_pkg::addr_t      mem_addr_2;
  osc_pkg::sample_t    mem_data_2;
  wire                 sclk;
  wire                 sdata;
  wire                 cs_n;
  wire                 cold_reset;
  wire                 warm_reset;
  wire                 debug_reset;
  osc_pkg::status_t    oscope_status;
  logic                finish_chk;
  int                  err_cnt;
  integer              seed;

  // ======================================================================
  // stimulus table: operation, channel, argument
  // ======================================================================
  int step_op [0:N_STEPS-1] = '{
    OP_TB, OP_IDLE, OP_TRIG_UP, OP_IDLE, OP_TRIG_UP, OP_IDLE, OP_TRIG_DN, OP_TRIG_DN,
    OP_IDLE, OP_TRIG_UP, OP_IDLE, OP_TRIG_DN, OP_ARM, OP_ARM, OP_TB, OP_IDLE,
    OP_TRIG_UP, OP_IDLE, OP_TB, OP_ENC_UP, OP_ENC_DN, OP_ENC_UP, OP_ENC_DN, OP_RST,
    OP_RST, OP_IDLE, OP_RST, OP_IDLE, OP_RST, OP_IDLE
  };
  int step_ch [0:N_STEPS-1] = '{
    0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 1, 0, 0,
    1, 0, 0, 0, 1, 1, 0, 0, 2, 0, 2, 0, 1, 0
  };
  int step_arg [0:N_STEPS-1] = '{
    3, 10, 0, 20, 0, 320, 0, 0, 10, 0, 20, 0, 0, 0, 0, 5,
    0, 100, 7, 5, 3, 140, 140, 0, 0, 5, 0, 40, 0, 20
  };

  osc_top dut (.*);

  osc_checker u_checker (.*);

  always #20 clk_50 = ~clk_50;

  // random adc samples on every edge
  always @(posedge clk_50) begin
    adc_samples_1 <= osc_pkg::sample_t'($random(seed));
    adc_samples_2 <= osc_pkg::sample_t'($random(seed));
  end

  task automatic idle(input int n);
    repeat (n) @(posedge clk_50);
  endtask

  // one detent: b sets direction, then a pulse on a
  task automatic encoder_step(input int ch, input logic down);
    @(posedge clk_50);
    if (ch == 0) re_b1 <= down;
    else         re_b2 <= down;
    idle(2);
    if (ch == 0) re_a1 <= 1'b1;
    else         re_a2 <= 1'b1;
    idle(4);
    if (ch == 0) re_a1 <= 1'b0;
    else         re_a2 <= 1'b0;
    idle(3);
  endtask

  task automatic apply_step(input int op, input int ch, input int arg);
    @(posedge clk_50);
    case (op)
      OP_TB:      time_base <= osc_pkg::time_base_t'(arg);
      OP_TRIG_UP: begin
        if (ch == 0) trigger_1 <= 1'b1;
        else         trigger_2 <= 1'b1;
      end
      OP_TRIG_DN: begin
        if (ch == 0) trigger_1 <= 1'b0;
        else         trigger_2 <= 1'b0;
      end
      OP_ARM: begin
        if (ch == 0) arm_1 <= 1'b1;
        else         arm_2 <= 1'b1;
        @(posedge clk_50);
        arm_1 <= 1'b0;
        arm_2 <= 1'b0;
      end
      OP_ENC_UP: repeat (arg) encoder_step(ch, 1'b0);
      OP_ENC_DN: repeat (arg) encoder_step(ch, 1'b1);
      OP_RST: begin
        reset_req[ch] <= 1'b1;
        idle(2);
        reset_req[ch] <= 1'b0;
      end
      default: idle(arg);
    endcase
  endtask

  // dac idle for 300 cycles in a row, bounded
  task automatic wait_dac_quiet();
    int quiet;
    int spent;
    quiet = 0;
    spent = 0;
    while (quiet < 300) begin
      @(posedge clk_50);
      quiet = cs_n ? quiet + 1 : 0;
      spent++;
      if (spent > 20000) begin
        $display("timeout: dac link never went quiet");
        $display("Test failed");
        $finish;
      end
    end
  endtask

  initial begin
    seed = 32'he537_a409;
    clk_50 = 1'b0;
    arst_n = 1'b0;
    time_base = '0;
    adc_samples_1 = '0;
    adc_samples_2 = '0;
    trigger_1 = 1'b0;
    trigger_2 = 1'b0;
    arm_1 = 1'b0;
    arm_2 = 1'b0;
    re_a1 = 1'b0;
    re_b1 = 1'b0;
    re_a2 = 1'b0;
    re_b2 = 1'b0;
    reset_req = '0;
    finish_chk = 1'b0;
    repeat (5) @(posedge clk_50);
    arst_n <= 1'b1;
    idle(3);
    for (int i = 0; i < N_STEPS; i++)
      apply_step(step_op[i], step_ch[i], step_arg[i]);
    wait_dac_quiet();
    finish_chk <= 1'b1;
    idle(3);
    if (err_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // overall watchdog
  initial begin
    #2_000_000;
    $display("timeout: simulation ran past its time limit");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
src/osc_pkg.sv
src/sample_clock_gen.sv
src/capture_channel.sv
src/quad_encoder_level.sv
src/dac_spi_writer.sv
src/reset_pulse_stretch.sv
src/osc_top.sv
verif/osc_checker.sv
verif/tb_osc_top.sv

// File: run.sh
#!/bin/sh
# build and run the oscilloscope testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_osc_top -o sim_osc
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_osc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

echo "$out" | grep -qx "Test passed" || exit 1
exit 0
